// ==== design/pipeline_pkg.sv ====
// shared widths, ISA encodings, instruction views and stage packets; imported by every stage
`default_nettype none

package pipeline_pkg;

    ////////////////////////////////////////////////////////////
    // widths and counts
    ////////////////////////////////////////////////////////////

    // data and address width
    localparam int xlen = 32;
    // architectural registers
    localparam int reg_count = 32;
    localparam int reg_idx_bits = 5;

    // pc numbering for accepted words
    localparam logic [xlen-1:0] npc_step = 32'd4;
    localparam logic [xlen-1:0] pc_reset = 32'd0;

    // rv32i alu opcodes
    localparam logic [6:0] opcode_reg = 7'b0110011;
    localparam logic [6:0] opcode_imm = 7'b0010011;

    ////////////////////////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////////////////////////

    // register-register layout
    typedef struct packed {
        logic [6:0]              funct7;
        logic [reg_idx_bits-1:0] rs2;
        logic [reg_idx_bits-1:0] rs1;
        logic [2:0]              funct3;
        logic [reg_idx_bits-1:0] rd;
        logic [6:0]              opcode;
    } r_fields_t;

    // register-immediate layout
    // imm[10] doubles as the srai select bit
    typedef struct packed {
        logic [11:0]             imm;
        logic [reg_idx_bits-1:0] rs1;
        logic [2:0]              funct3;
        logic [reg_idx_bits-1:0] rd;
        logic [6:0]              opcode;
    } i_fields_t;

    // same 32 bits, read either way
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } inst_t;

    // alu operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5,
        alu_sltu = 4'd6,
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_func_e;

    ////////////////////////////////////////////////////////////
    // stage packets
    ////////////////////////////////////////////////////////////

    // fetch to decode
    typedef struct packed {
        logic            valid;
        inst_t           inst;
        logic [xlen-1:0] npc;
    } if_id_packet_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        logic                    valid;
        logic [xlen-1:0]         opa;
        logic [xlen-1:0]         opb;
        alu_func_e               alu_func;
        logic                    has_dest;
        logic [reg_idx_bits-1:0] dest_idx;
        logic [xlen-1:0]         npc;
    } id_ex_packet_t;

    // execute result, also the register file write port
    typedef struct packed {
        logic                    valid;
        logic                    wr_en;
        logic [reg_idx_bits-1:0] wr_idx;
        logic [xlen-1:0]         wr_data;
        logic [xlen-1:0]         npc;
    } commit_packet_t;

endpackage

`default_nettype wire

// ==== design/stage_if.sv ====
// fetch stage: takes instruction words over valid/ready, tags each with its npc, holds IF/ID
`timescale 1ns/10ps
`default_nettype none

module stage_if
    import pipeline_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          inst_valid,
    input  inst_t         inst_data,
    input  logic          id_ready,
    output logic          inst_ready,
    output if_id_packet_t if_id
);

    // IF/ID register, control half
    logic            valid_q;
    // npc handed to the next accepted word
    logic [xlen-1:0] pc_q;
    // IF/ID register, payload half
    inst_t           inst_q;
    logic [xlen-1:0] npc_q;
    // inlet handshake fires
    logic            take;

    ////////////////////////////////////////////////////////////
    // inlet handshake
    ////////////////////////////////////////////////////////////

    // room when empty, or when decode drains it this cycle
    assign inst_ready = !valid_q || id_ready;
    assign take = inst_valid && inst_ready;

    ////////////////////////////////////////////////////////////
    // pc counter and IF/ID valid
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            pc_q    <= pc_reset;
        end else begin
            if (take) begin
                valid_q <= 1'b1;
                // one step per accepted word
                pc_q    <= pc_q + npc_step;
            end else if (id_ready) begin
                // item left, nothing new behind it
                valid_q <= 1'b0;
            end
            // otherwise decode stalls, hold
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clock) begin
        if (take) begin
            inst_q <= inst_data;
            npc_q  <= pc_q;
        end
    end

    // packet out to decode
    always_comb begin
        if_id.valid = valid_q;
        if_id.inst  = inst_q;
        if_id.npc   = npc_q;
    end

endmodule

`default_nettype wire

// ==== design/stage_id.sv ====
// decode stage with ALU format decode, operand select, busy scoreboard and the ID/EX register
`timescale 1ns/10ps
`default_nettype none

module stage_id
    import pipeline_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  if_id_packet_t           if_id,
    input  logic [xlen-1:0]         rs1_value,
    input  logic [xlen-1:0]         rs2_value,
    input  commit_packet_t          commit,
    output logic [reg_idx_bits-1:0] rs1_idx,
    output logic [reg_idx_bits-1:0] rs2_idx,
    output logic                    id_ready,
    output id_ex_packet_t           id_ex
);

    inst_t                   inst;
    logic                    is_reg;
    logic                    is_imm;
    alu_func_e               func;
    logic [xlen-1:0]         opb;
    logic                    has_dest;
    // scoreboard with one bit per register
    logic [reg_count-1:0]    busy_q;
    logic [reg_count-1:0]    busy_now;
    logic [reg_count-1:0]    set_mask;
    logic [reg_count-1:0]    clear_mask;
    logic                    keep_busy;
    logic                    stall;
    logic                    advance;
    // ID/EX register
    logic                    valid_q;
    logic [xlen-1:0]         opa_q;
    logic [xlen-1:0]         opb_q;
    alu_func_e               func_q;
    logic                    has_dest_q;
    logic [reg_idx_bits-1:0] dest_q;
    logic [xlen-1:0]         npc_q;

    ////////////////////////////////////////////////////////////
    // format decode
    ////////////////////////////////////////////////////////////

    assign inst   = if_id.inst;
    assign is_reg = (inst.r.opcode == opcode_reg);
    assign is_imm = (inst.r.opcode == opcode_imm);

    // rs1 sits in the same bits in both views
    assign rs1_idx = inst.r.rs1;
    assign rs2_idx = inst.r.rs2;

    // rd of x0 means no write
    assign has_dest = (is_reg || is_imm) && (inst.r.rd != '0);

    always_comb begin
        func = alu_add;
        opb  = rs2_value;
        if (is_reg) begin
            case (inst.r.funct3)
                3'd0: func = inst.r.funct7[5] ? alu_sub : alu_add;
                3'd1: func = alu_sll;
                3'd2: func = alu_slt;
                3'd3: func = alu_sltu;
                3'd4: func = alu_xor;
                3'd5: func = inst.r.funct7[5] ? alu_sra : alu_srl;
                3'd6: func = alu_or;
                default: func = alu_and;
            endcase
        end else if (is_imm) begin
            // sign-extended immediate by default
            opb = {{(xlen-12){inst.i.imm[11]}}, inst.i.imm};
            case (inst.i.funct3)
                3'd0: func = alu_add;
                3'd1: func = alu_sll;
                3'd2: func = alu_slt;
                3'd3: func = alu_sltu;
                3'd4: func = alu_xor;
                3'd5: func = inst.i.imm[10] ? alu_sra : alu_srl;
                3'd6: func = alu_or;
                default: func = alu_and;
            endcase
            // shift-immediates carry shamt in imm[4:0]
            if (inst.i.funct3 == 3'd1 || inst.i.funct3 == 3'd5) begin
                opb = {{(xlen-5){1'b0}}, inst.i.imm[4:0]};
            end
        end
        // unknown opcode falls through as a no-op add
    end

    ////////////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////////////

    // a younger writer of the same register sitting in ID/EX keeps it busy
    assign keep_busy  = valid_q && has_dest_q && (dest_q == commit.wr_idx);
    // a commit frees its register this cycle and regfile forwards the data
    assign clear_mask = (commit.wr_en && !keep_busy) ? (reg_count'(1) << commit.wr_idx) : '0;
    assign busy_now   = busy_q & ~clear_mask;

    // imm forms only read rs1
    assign stall = ((is_reg || is_imm) && busy_now[inst.r.rs1])
                || (is_reg && busy_now[inst.r.rs2]);

    assign id_ready = !(if_id.valid && stall);
    assign advance  = if_id.valid && !stall;

    assign set_mask = (advance && has_dest) ? (reg_count'(1) << inst.r.rd) : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy_q <= '0;
        end else begin
            // a new writer wins over a same-edge commit
            busy_q <= busy_now | set_mask;
        end
    end

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////

    // execute never stalls so a bubble enters when nothing advances
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= advance;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            opa_q      <= rs1_value;
            opb_q      <= opb;
            func_q     <= func;
            has_dest_q <= has_dest;
            dest_q     <= inst.r.rd;
            npc_q      <= if_id.npc;
        end
    end

    always_comb begin
        id_ex.valid    = valid_q;
        id_ex.opa      = opa_q;
        id_ex.opb      = opb_q;
        id_ex.alu_func = func_q;
        id_ex.has_dest = has_dest_q;
        id_ex.dest_idx = dest_q;
        id_ex.npc      = npc_q;
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// architectural register file: x0 hardwired to zero, two read ports, write-through on commit
`timescale 1ns/10ps
`default_nettype none

module reg_file
    import pipeline_pkg::*;
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic [reg_idx_bits-1:0] rs1_idx,
    input  logic [reg_idx_bits-1:0] rs2_idx,
    input  commit_packet_t          commit,
    output logic [xlen-1:0]         rs1_value,
    output logic [xlen-1:0]         rs2_value
);

    // x1..x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];

    // one read port, bypassing the write in flight
    function automatic logic [xlen-1:0] read_port(input logic [reg_idx_bits-1:0] idx);
        logic [xlen-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (commit.wr_en && commit.wr_idx == idx) begin
            value = commit.wr_data;
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    // architectural state starts at zero
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int k = 1; k < reg_count; k++) begin
                regs[k] <= '0;
            end
        end else if (commit.wr_en && commit.wr_idx != '0) begin
            regs[commit.wr_idx] <= commit.wr_data;
        end
    end

    assign rs1_value = read_port(rs1_idx);
    assign rs2_value = read_port(rs2_idx);

endmodule

`default_nettype wire

// ==== design/stage_ex.sv ====
// execute stage: ALU on resolved operands, registered commit packet that writes the register file
`timescale 1ns/10ps
`default_nettype none

module stage_ex
    import pipeline_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  id_ex_packet_t  id_ex,
    output commit_packet_t commit
);

    logic [xlen-1:0]         result;
    logic [4:0]              shamt;
    // commit register, control half
    logic                    valid_q;
    logic                    wr_en_q;
    // commit register, payload half
    logic [reg_idx_bits-1:0] wr_idx_q;
    logic [xlen-1:0]         wr_data_q;
    logic [xlen-1:0]         npc_q;

    ////////////////////////////////////////////////////////////
    // alu
    ////////////////////////////////////////////////////////////

    // shifts use the low five bits only
    assign shamt = id_ex.opb[4:0];

    always_comb begin
        case (id_ex.alu_func)
            alu_add:  result = id_ex.opa + id_ex.opb;
            alu_sub:  result = id_ex.opa - id_ex.opb;
            alu_and:  result = id_ex.opa & id_ex.opb;
            alu_or:   result = id_ex.opa | id_ex.opb;
            alu_xor:  result = id_ex.opa ^ id_ex.opb;
            // compares give 0 or 1
            alu_slt:  result = {{(xlen-1){1'b0}}, $signed(id_ex.opa) < $signed(id_ex.opb)};
            alu_sltu: result = {{(xlen-1){1'b0}}, id_ex.opa < id_ex.opb};
            alu_sll:  result = id_ex.opa << shamt;
            alu_srl:  result = id_ex.opa >> shamt;
            alu_sra:  result = $unsigned($signed(id_ex.opa) >>> shamt);
            default:  result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // commit register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            valid_q <= id_ex.valid;
            // no-ops and x0 targets arrive with has_dest low
            wr_en_q <= id_ex.valid && id_ex.has_dest;
        end
    end

    always_ff @(posedge clock) begin
        wr_idx_q  <= id_ex.dest_idx;
        wr_data_q <= result;
        npc_q     <= id_ex.npc;
    end

    always_comb begin
        commit.valid   = valid_q;
        commit.wr_en   = wr_en_q;
        commit.wr_idx  = wr_idx_q;
        commit.wr_data = wr_data_q;
        commit.npc     = npc_q;
    end

endmodule

`default_nettype wire

// ==== design/pipeline.sv ====
// top level of the in-order ALU pipeline: fetch, decode, execute and the register file
`timescale 1ns/10ps
`default_nettype none

module pipeline
    import pipeline_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    // instruction inlet
    input  logic           inst_valid,
    input  inst_t          inst_data,
    output logic           inst_ready,
    // one packet per retired word
    output commit_packet_t commit
);

    ////////////////////////////////////////////////////////////
    // stage links
    ////////////////////////////////////////////////////////////

    if_id_packet_t           if_id;
    logic                    id_ready;
    id_ex_packet_t           id_ex;
    // register file read ports
    logic [reg_idx_bits-1:0] rs1_idx;
    logic [reg_idx_bits-1:0] rs2_idx;
    logic [xlen-1:0]         rs1_value;
    logic [xlen-1:0]         rs2_value;

    // fetch
    stage_if u_stage_if (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .id_ready   (id_ready),
        .inst_ready (inst_ready),
        .if_id      (if_id)
    );

    // decode and scoreboard
    stage_id u_stage_id (
        .clock     (clock),
        .reset     (reset),
        .if_id     (if_id),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .commit    (commit),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .id_ready  (id_ready),
        .id_ex     (id_ex)
    );

    // written by commit, read by decode
    reg_file u_reg_file (
        .clock     (clock),
        .reset     (reset),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .commit    (commit),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    // execute, drives commit
    stage_ex u_stage_ex (
        .clock  (clock),
        .reset  (reset),
        .id_ex  (id_ex),
        .commit (commit)
    );

endmodule

`default_nettype wire

// ==== include/tb_model.svh ====
// reference model of the register file and ALU, included inside the testbench module
`ifndef tb_model_svh
`define tb_model_svh

////////////////////////////////////////////////////////////
// architectural state
////////////////////////////////////////////////////////////

// x0 stays zero, it is never written
logic [xlen-1:0] model_regs [0:reg_count-1];

task automatic model_reset();
    for (int k = 0; k < reg_count; k++) begin
        model_regs[k] = '0;
    end
endtask

// rv32i alu by funct3, alt picks sub or sra
function automatic logic [xlen-1:0] model_alu(input logic [2:0] funct3, input logic alt,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    logic [xlen-1:0] r;
    case (funct3)
        3'd0: begin
            if (alt) r = a - b;
            else r = a + b;
        end
        3'd1: r = a << b[4:0];
        3'd2: r = ($signed(a) < $signed(b)) ? 1 : 0;
        3'd3: r = (a < b) ? 1 : 0;
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) r = $signed(a) >>> b[4:0];
            else r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// retire one word in order, return the commit it should produce
task automatic model_retire(input inst_t w, input logic [xlen-1:0] npc,
                            output commit_packet_t exp);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] data;
    logic            alt;
    logic            is_alu;
    a      = model_regs[w.r.rs1];
    b      = '0;
    alt    = 1'b0;
    data   = '0;
    is_alu = 1'b1;
    if (w.r.opcode == opcode_reg) begin
        b   = model_regs[w.r.rs2];
        alt = w.r.funct7[5] && (w.r.funct3 == 3'd0 || w.r.funct3 == 3'd5);
    end else if (w.r.opcode == opcode_imm) begin
        // sign-extended, shifts only look at the low five bits
        b   = {{(xlen-12){w.i.imm[11]}}, w.i.imm};
        alt = (w.i.funct3 == 3'd5) && w.i.imm[10];
    end else begin
        is_alu = 1'b0;
    end
    if (is_alu) begin
        data = model_alu(w.r.funct3, alt, a, b);
    end
    exp         = '0;
    exp.valid   = 1'b1;
    exp.wr_en   = is_alu && (w.r.rd != '0);
    exp.wr_idx  = w.r.rd;
    exp.wr_data = data;
    exp.npc     = npc;
    if (exp.wr_en) begin
        model_regs[w.r.rd] = data;
    end
endtask

`endif

// ==== sim/pipeline_tb.sv ====
// ALU pipeline testbench driving random words and checking commits in order against a model
`timescale 1ns/10ps
`default_nettype none

module pipeline_tb
    import pipeline_pkg::*;
();

    localparam int total_words      = 2000;
    localparam int reset_cycles     = 16;
    localparam int reset_wait_limit = 20;
    localparam int run_limit        = 40000;
    localparam int drain_limit      = 200;
    localparam int quiet_cycles     = 8;

    logic           clock;
    logic           reset;
    logic           inst_valid;
    inst_t          inst_data;
    logic           inst_ready;
    commit_packet_t commit;

    integer          seed = 13;
    logic            running;
    int unsigned     accepted;
    int unsigned     committed;
    inst_t           expected_q [$];
    // dependency chain state
    int unsigned     chain_left;
    logic [4:0]      last_rd;

    `include "tb_model.svh"

    pipeline u_pipeline (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_ready (inst_ready),
        .commit     (commit)
    );

    // 4 ns period
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // failure reporting and compares
    ////////////////////////////////////////////////////////////

    task automatic end_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic report_timeout(input string msg);
        $display("timeout at time %0t: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic compare_commit(input commit_packet_t got, input commit_packet_t exp);
        if (got.valid !== exp.valid || got.wr_en !== exp.wr_en || got.npc !== exp.npc) begin
            report_mismatch($sformatf("commit npc %h wr_en %b, expected npc %h wr_en %b",
                                      got.npc, got.wr_en, exp.npc, exp.wr_en));
        end
        // index and data only matter when a write happens
        if (exp.wr_en && (got.wr_idx !== exp.wr_idx || got.wr_data !== exp.wr_data)) begin
            report_mismatch($sformatf("npc %h wrote x%0d = %h, expected x%0d = %h",
                                      got.npc, got.wr_idx, got.wr_data,
                                      exp.wr_idx, exp.wr_data));
        end
    endtask

    task automatic compare_count(input int unsigned acc, input int unsigned com);
        if (com != acc) begin
            report_mismatch($sformatf("accepted %0d committed %0d, expected equal totals",
                                      acc, com));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // random instruction words
    ////////////////////////////////////////////////////////////

    function automatic logic roll_percent(input int unsigned percent);
        return ($unsigned($random(seed)) % 100) < percent;
    endfunction

    // small register set half the time for more hazards
    function automatic logic [4:0] pick_reg();
        logic [4:0] r;
        r = $random(seed);
        if (roll_percent(50)) r[4:3] = 2'b00;
        return r;
    endfunction

    task automatic build_word(output inst_t w);
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic        alt;
        kind = $unsigned($random(seed)) % 100;
        rd   = pick_reg();
        rs1  = pick_reg();
        rs2  = pick_reg();
        f3   = $random(seed);
        alt  = $random(seed);
        if (chain_left == 0 && roll_percent(6)) chain_left = 4 + $unsigned($random(seed)) % 9;
        // chain member reads the previous destination
        if (chain_left > 0) begin
            rs1 = last_rd;
            if (roll_percent(50)) rs2 = last_rd;
            if (rd == '0) rd = 5'd9;
            chain_left--;
        end
        w = $random(seed);
        if (kind < 45) begin
            w.r.funct7 = (alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0000000;
            w.r.rs2    = rs2;
            w.r.opcode = opcode_reg;
        end else if (kind < 92) begin
            // full random imm including negatives
            if (f3 == 3'd1) w.i.imm[11:5] = 7'b0000000;
            if (f3 == 3'd5) w.i.imm[11:5] = alt ? 7'b0100000 : 7'b0000000;
            w.i.opcode = opcode_imm;
        end else if (w.r.opcode == opcode_reg || w.r.opcode == opcode_imm) begin
            // force a non-alu opcode
            w.r.opcode = w.r.opcode ^ 7'b1000000;
        end
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        last_rd    = rd;
    endtask

    ////////////////////////////////////////////////////////////
    // commit checking and inlet driving
    ////////////////////////////////////////////////////////////

    // samples pre-edge values and drives with nba
    always @(posedge clock) begin
        inst_t          word;
        commit_packet_t exp;
        if (running) begin
            if (commit.valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    report_mismatch("commit with no accepted word outstanding");
                end
                word = expected_q.pop_front();
                model_retire(word, pc_reset + npc_step * committed, exp);
                compare_commit(commit, exp);
                committed++;
            end
            if (inst_valid && inst_ready) begin
                expected_q.push_back(inst_data);
                accepted++;
            end
            // new offer only once the last one is taken
            if (!inst_valid || inst_ready) begin
                if (accepted < total_words && roll_percent(70)) begin
                    build_word(word);
                    inst_valid <= 1'b1;
                    inst_data  <= word;
                end else begin
                    inst_valid <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // run sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int unsigned cycles;
        int unsigned quiet;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst_data  = '0;
        running    = 1'b0;
        accepted   = 0;
        committed  = 0;
        chain_left = 0;
        last_rd    = '0;
        model_reset();
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b0;
        // reset wait
        cycles = 0;
        @(posedge clock);
        while (inst_ready !== 1'b1) begin
            cycles++;
            if (cycles > reset_wait_limit) report_timeout("inst_ready never rose after reset");
            @(posedge clock);
        end
        if (commit.valid !== 1'b0) report_mismatch("commit.valid high right after reset");
        running <= 1'b1;
        // stream wait
        cycles = 0;
        while (accepted < total_words) begin
            @(negedge clock);
            cycles++;
            if (cycles > run_limit) report_timeout("not all instruction words were accepted");
        end
        // drain wait until commit stays quiet, stray commits fail on an empty queue
        cycles = 0;
        quiet  = 0;
        while (quiet < quiet_cycles) begin
            @(negedge clock);
            cycles++;
            if (commit.valid === 1'b1) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (cycles > drain_limit) report_timeout("pipeline did not drain its commits");
        end
        compare_count(accepted, committed);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/pipeline_pkg.sv
design/stage_if.sv
design/stage_id.sv
design/reg_file.sv
design/stage_ex.sv
design/pipeline.sv
sim/pipeline_tb.sv

// ==== Bender.yml ====
package:
  name: pipeline

sources:
  # synthesizable design, package first
  - files:
      - design/pipeline_pkg.sv
      - design/stage_if.sv
      - design/stage_id.sv
      - design/reg_file.sv
      - design/stage_ex.sv
      - design/pipeline.sv

  # testbench and its reference model header
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/pipeline_tb.sv

# top levels: pipeline for synthesis, pipeline_tb for simulation
